//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := udma_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))
HDRS      := $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
+incdir+src
src/udma_pkg.sv
src/udma_apb_cfg.sv
src/udma_lin_tx_ch.sv
src/udma_l2_rd_arb.sv
src/udma_subsystem.sv
dv/udma_tb.sv

//--- dv/udma_tb.sv
// testbench for udma_subsystem; needs UDMA_N_CH of 2 or more, random grant, L2 latency 1 to 4 cycles
`include "udma_defines.svh"

`default_nettype none

module udma_tb;

    import udma_pkg::*;

    localparam int N_CH    = `UDMA_N_CH;
    localparam int N_SLOTS = 1 << `UDMA_SLOT_WIDTH;
    localparam int TIMEOUT = 2000;
    localparam l2_data_t SIZE_MASK =
        {{(`UDMA_L2_WIDTH - `UDMA_TRANS_SIZE){1'b0}}, {`UDMA_TRANS_SIZE{1'b1}}};

    logic                              sys_clk_i;
    logic                              rst_n_i;
    logic [`UDMA_APB_ADDR_WIDTH-1:0]   apb_paddr_i;
    l2_data_t                          apb_pwdata_i;
    logic                              apb_pwrite_i;
    logic                              apb_psel_i;
    logic                              apb_penable_i;
    l2_data_t                          apb_prdata_o;
    logic                              apb_pready_o;
    logic                              apb_pslverr_o;
    logic                              l2_req_o;
    l2_addr_t                          l2_addr_o;
    logic                              l2_gnt_i;
    logic                              l2_rvalid_i;
    l2_data_t                          l2_rdata_i;
    logic [N_CH-1:0]                   tx_valid_o;
    l2_data_t [N_CH-1:0]               tx_data_o;
    udma_evt_t [`UDMA_EVT_SLOTS-1:0]   events_o;

    // expected stream words of each channel
    l2_data_t  exp_q [N_CH][$];
    int        word_cnt [N_CH] = '{default: 0};
    int        eot_cnt [N_CH] = '{default: 0};
    int        errors = 0;
    int        unused_errs = 0;
    int        tests_run = 0;
    int        tests_failed = 0;

    // L2 reads in flight in request order
    l2_addr_t  rd_addr_q [$];
    int        rd_due_q [$];
    int        cycle_cnt = 0;
    int        last_due = 0;

    udma_subsystem udma_subsystem_i (.*);

    initial begin
        sys_clk_i = 1'b0;
        forever #50 sys_clk_i = ~sys_clk_i;
    end

    // memory contents as a function of the word address
    function automatic l2_data_t mem_word(input l2_addr_t addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [`UDMA_APB_ADDR_WIDTH-1:0] apb_addr(input int slot, input int off);
        return {slot[4:0], off[4:0], 2'b00};
    endfunction

    task automatic check_val(input string what, input l2_data_t got, input l2_data_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int n_err);
        tests_run++;
        if (n_err == 0) begin
            $display("test %-20s ok", name);
        end else begin
            tests_failed++;
            $display("test %-20s failed with %0d errors", name, n_err);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // setup and access phases with zero wait states
    task automatic apb_access(input logic wr, input int slot, input int off,
                              input l2_data_t wdata, output l2_data_t rdata, output logic err);
        @(posedge sys_clk_i);
        apb_paddr_i   <= apb_addr(slot, off);
        apb_pwdata_i  <= wdata;
        apb_pwrite_i  <= wr;
        apb_psel_i    <= 1'b1;
        apb_penable_i <= 1'b0;
        @(posedge sys_clk_i);
        apb_penable_i <= 1'b1;
        @(negedge sys_clk_i);
        rdata = apb_prdata_o;
        err   = apb_pslverr_o;
        check_val("pready in access phase", l2_data_t'(apb_pready_o), 1);
        @(posedge sys_clk_i);
        apb_psel_i    <= 1'b0;
        apb_penable_i <= 1'b0;
    endtask

    task automatic apb_write(input int slot, input int off, input l2_data_t wdata);
        l2_data_t rd;
        logic     err;
        apb_access(1'b1, slot, off, wdata, rd, err);
    endtask

    task automatic apb_read(input int slot, input int off, output l2_data_t rdata,
                            output logic err);
        apb_access(1'b0, slot, off, '0, rdata, err);
    endtask

    task automatic program_channel(input int ch, input l2_addr_t saddr, input l2_data_t bytes);
        apb_write(ch, `UDMA_REG_SADDR, saddr);
        apb_write(ch, `UDMA_REG_SIZE, bytes);
        for (int i = 0; i < int'(bytes) / 4; i++) begin
            exp_q[ch].push_back(mem_word(saddr + l2_addr_t'(4 * i)));
        end
    endtask

    task automatic start_channel(input int ch);
        apb_write(ch, `UDMA_REG_CFG, 32'h1);
    endtask

    task automatic wait_eot(input int ch, input int target);
        int cycles;
        cycles = 0;
        while (eot_cnt[ch] < target && cycles < TIMEOUT) begin
            @(negedge sys_clk_i);
            cycles++;
        end
        if (eot_cnt[ch] < target) begin
            abort_run($sformatf("timeout: channel %0d never signalled end of transfer", ch));
        end
    endtask

    // L2 slave with random grant and in-order replies
    always @(posedge sys_clk_i) begin
        int due;
        cycle_cnt++;
        l2_rvalid_i <= 1'b0;
        if (rd_due_q.size() != 0 && rd_due_q[0] == cycle_cnt) begin
            l2_rvalid_i <= 1'b1;
            l2_rdata_i  <= mem_word(rd_addr_q.pop_front());
            void'(rd_due_q.pop_front());
        end
        if (rst_n_i && l2_req_o && l2_gnt_i) begin
            due = cycle_cnt + 1 + int'($urandom % 4);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            rd_addr_q.push_back(l2_addr_o);
            rd_due_q.push_back(due);
        end
        l2_gnt_i <= rst_n_i && (($urandom % 4) != 0);
    end

    // stream and event monitor
    always @(negedge sys_clk_i) begin
        l2_data_t  exp_word;
        logic      last_word;
        udma_evt_t bad;
        if (rst_n_i) begin
            for (int c = 0; c < N_CH; c++) begin
                if (tx_valid_o[c]) begin
                    word_cnt[c]++;
                    if (exp_q[c].size() == 0) begin
                        errors++;
                        $display("channel %0d sent a word nobody asked for at t=%0t", c, $time);
                    end else begin
                        exp_word  = exp_q[c].pop_front();
                        last_word = exp_q[c].size() == 0;
                        check_val($sformatf("ch%0d tx data", c), tx_data_o[c], exp_word);
                        check_val($sformatf("ch%0d eot with word", c),
                                  l2_data_t'(events_o[c][0]), l2_data_t'(last_word));
                    end
                end else begin
                    check_val($sformatf("ch%0d eot without word", c),
                              l2_data_t'(events_o[c][0]), 0);
                end
                if (events_o[c][0]) begin
                    eot_cnt[c]++;
                end
            end
            bad = '0;
            for (int s = 0; s < `UDMA_EVT_SLOTS; s++) begin
                if (s < N_CH) begin
                    bad = bad | (events_o[s] & 4'hE);
                end else begin
                    bad = bad | events_o[s];
                end
            end
            if (bad != '0) begin
                unused_errs++;
            end
            check_val("unused event bits", l2_data_t'(bad), 0);
        end
    end

    initial begin
        l2_data_t rd;
        l2_data_t sa [N_CH];
        l2_data_t sz [N_CH];
        l2_data_t prev_left;
        logic     err;
        int       ch;
        int       base;
        int       bad_slot;
        int       w0 [N_CH];
        int       e0 [N_CH];

        void'($urandom(32'h3c2f_e735));
        rst_n_i       = 1'b0;
        apb_paddr_i   = '0;
        apb_pwdata_i  = '0;
        apb_pwrite_i  = 1'b0;
        apb_psel_i    = 1'b0;
        apb_penable_i = 1'b0;
        l2_gnt_i      = 1'b0;
        l2_rvalid_i   = 1'b0;
        l2_rdata_i    = '0;
        repeat (4) @(posedge sys_clk_i);
        rst_n_i <= 1'b1;

        base = errors;
        @(negedge sys_clk_i);
        check_val("events after reset", l2_data_t'(|events_o), 0);
        check_val("l2_req after reset", l2_data_t'(l2_req_o), 0);
        check_val("tx_valid after reset", l2_data_t'(|tx_valid_o), 0);
        check_val("pslverr after reset", l2_data_t'(apb_pslverr_o), 0);
        for (int c = 0; c < N_CH; c++) begin
            for (int off = 0; off < 4; off++) begin
                apb_read(c, off, rd, err);
                check_val($sformatf("ch%0d reg %0d after reset", c, off), rd, 0);
                check_val($sformatf("ch%0d reg %0d pslverr", c, off), l2_data_t'(err), 0);
            end
        end
        report_test("reset state", errors - base);

        base = errors;
        for (int c = 0; c < N_CH; c++) begin
            sa[c] = $urandom;
            sz[c] = $urandom;
            apb_write(c, `UDMA_REG_SADDR, sa[c]);
            apb_write(c, `UDMA_REG_SIZE, sz[c]);
        end
        for (int c = 0; c < N_CH; c++) begin
            apb_read(c, `UDMA_REG_SADDR, rd, err);
            check_val($sformatf("ch%0d saddr readback", c), rd, sa[c]);
            apb_read(c, `UDMA_REG_SIZE, rd, err);
            check_val($sformatf("ch%0d size readback", c), rd, sz[c] & SIZE_MASK);
        end
        bad_slot = N_CH + int'($urandom % (N_SLOTS - N_CH));
        apb_access(1'b1, bad_slot, `UDMA_REG_SADDR, $urandom, rd, err);
        check_val("pslverr on unmapped write", l2_data_t'(err), 1);
        apb_read(bad_slot, `UDMA_REG_SADDR, rd, err);
        check_val("pslverr on unmapped read", l2_data_t'(err), 1);
        check_val("prdata on unmapped read", rd, 0);
        for (int c = 0; c < N_CH; c++) begin
            apb_read(c, `UDMA_REG_SADDR, rd, err);
            check_val($sformatf("ch%0d saddr kept", c), rd, sa[c]);
        end
        report_test("register access", errors - base);

        base = errors;
        ch = int'($urandom % N_CH);
        w0[ch] = word_cnt[ch];
        e0[ch] = eot_cnt[ch];
        sz[ch] = 4 * (1 + ($urandom % 16));
        program_channel(ch, $urandom & ~32'h3, sz[ch]);
        start_channel(ch);
        wait_eot(ch, e0[ch] + 1);
        check_val("single words delivered", word_cnt[ch] - w0[ch], sz[ch] / 4);
        check_val("single words missing", exp_q[ch].size(), 0);
        report_test("single transfer", errors - base);

        base = errors;
        ch = int'($urandom % N_CH);
        e0[ch] = eot_cnt[ch];
        program_channel(ch, $urandom & ~32'h3, 64);
        start_channel(ch);
        apb_read(ch, `UDMA_REG_CFG, rd, err);
        check_val("busy while running", l2_data_t'(rd[1]), 1);
        apb_write(ch, `UDMA_REG_SIZE, $urandom);
        prev_left = 64;
        repeat (6) begin
            apb_read(ch, `UDMA_REG_LEFT, rd, err);
            check_val("left never increases", l2_data_t'(rd > prev_left), 0);
            prev_left = rd;
        end
        wait_eot(ch, e0[ch] + 1);
        apb_read(ch, `UDMA_REG_CFG, rd, err);
        check_val("busy after eot", l2_data_t'(rd[1]), 0);
        apb_read(ch, `UDMA_REG_LEFT, rd, err);
        check_val("left after eot", rd, 0);
        apb_read(ch, `UDMA_REG_SIZE, rd, err);
        check_val("size write while busy", rd, 64);
        report_test("busy status", errors - base);

        base = errors;
        for (int c = 0; c < N_CH; c++) begin
            w0[c] = word_cnt[c];
            e0[c] = eot_cnt[c];
            sz[c] = 4 * (1 + ($urandom % 16));
            program_channel(c, $urandom & ~32'h3, sz[c]);
        end
        for (int c = 0; c < N_CH; c++) begin
            start_channel(c);
        end
        for (int c = 0; c < N_CH; c++) begin
            wait_eot(c, e0[c] + 1);
            check_val($sformatf("ch%0d words delivered", c), word_cnt[c] - w0[c], sz[c] / 4);
            check_val($sformatf("ch%0d words missing", c), exp_q[c].size(), 0);
        end
        report_test("concurrent channels", errors - base);

        report_test("unused event bits", unused_errs);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/udma_apb_cfg.sv
// apb slave with zero wait states; pready is tied high, slots at or above UDMA_N_CH give pslverr
`include "udma_defines.svh"

`default_nettype none

module udma_apb_cfg (
    input  wire logic                                     sys_clk_i,
    input  wire logic                                     rst_n_i,
    input  wire logic [`UDMA_APB_ADDR_WIDTH-1:0]          apb_paddr_i,
    input  wire udma_pkg::l2_data_t                       apb_pwdata_i,
    input  wire logic                                     apb_pwrite_i,
    input  wire logic                                     apb_psel_i,
    input  wire logic                                     apb_penable_i,
    input  wire udma_pkg::l2_data_t [`UDMA_N_CH-1:0]      ch_rdata_i,
    output udma_pkg::l2_data_t                            apb_prdata_o,
    output logic                                          apb_pready_o,
    output logic                                          apb_pslverr_o,
    output udma_pkg::reg_addr_t                           cfg_addr_o,
    output udma_pkg::l2_data_t                            cfg_wdata_o,
    output logic [`UDMA_N_CH-1:0]                         cfg_we_o
);

    import udma_pkg::*;

    slot_id_t  slot;
    logic      access;
    logic      slot_ok;
    l2_data_t  rdata_sel;

    // slot in the top bits, word offset below it
    assign slot       = apb_paddr_i[`UDMA_APB_ADDR_WIDTH-1 -: `UDMA_SLOT_WIDTH];
    assign cfg_addr_o = apb_paddr_i[2 +: `UDMA_REG_ADDR_WIDTH];

    assign access  = apb_psel_i && apb_penable_i;
    assign slot_ok = int'(slot) < `UDMA_N_CH;

    assign cfg_wdata_o = apb_pwdata_i;

    // one write strobe, only for the addressed channel
    always_comb begin
        cfg_we_o = '0;
        for (int i = 0; i < `UDMA_N_CH; i++) begin
            if (access && apb_pwrite_i && slot_ok && (int'(slot) == i)) begin
                cfg_we_o[i] = 1'b1;
            end
        end
    end

    // read mux over the channel slots
    always_comb begin
        rdata_sel = '0;
        for (int i = 0; i < `UDMA_N_CH; i++) begin
            if (int'(slot) == i) begin
                rdata_sel = ch_rdata_i[i];
            end
        end
    end

    assign apb_prdata_o  = (access && slot_ok) ? rdata_sel : '0;
    assign apb_pready_o  = 1'b1;
    assign apb_pslverr_o = access && !slot_ok;

    // an error only ends a proper setup then access sequence
    a_pslverr_access: assert property (
        @(posedge sys_clk_i) disable iff (!rst_n_i)
        apb_pslverr_o |-> access && $past(apb_psel_i && !apb_penable_i)
    );

endmodule

`default_nettype wire

//--- src/udma_defines.svh
// one clock domain only; transfers are word aligned, sizes are multiples of 4 bytes
`ifndef UDMA_DEFINES_SVH
`define UDMA_DEFINES_SVH

// channel count, at most 32 slots
`define UDMA_N_CH            2

// apb address split: slot in 11:7, offset in 6:2
`define UDMA_APB_ADDR_WIDTH  12
`define UDMA_REG_ADDR_WIDTH  5
`define UDMA_SLOT_WIDTH      5

`define UDMA_L2_WIDTH        32
`define UDMA_TRANS_SIZE      20

`define UDMA_EVT_SLOTS       32
`define UDMA_EVT_WIDTH       4

// reads in flight, power of two
`define UDMA_ID_FIFO_DEPTH   4

// channel register offsets, in words
`define UDMA_REG_SADDR       5'h00
`define UDMA_REG_SIZE        5'h01
`define UDMA_REG_CFG         5'h02
`define UDMA_REG_LEFT        5'h03

`endif

//--- src/udma_l2_rd_arb.sv
// round-robin L2 read arbiter; L2 answers in request order, FIFO depth must be a power of two
`include "udma_defines.svh"

`default_nettype none

module udma_l2_rd_arb (
    input  wire logic                                  sys_clk_i,
    input  wire logic                                  rst_n_i,
    input  wire logic [`UDMA_N_CH-1:0]                 ch_req_i,
    input  wire udma_pkg::l2_addr_t [`UDMA_N_CH-1:0]   ch_addr_i,
    output logic [`UDMA_N_CH-1:0]                      ch_gnt_o,
    output logic [`UDMA_N_CH-1:0]                      ch_rvalid_o,
    output logic                                       l2_req_o,
    output udma_pkg::l2_addr_t                         l2_addr_o,
    input  wire logic                                  l2_gnt_i,
    input  wire logic                                  l2_rvalid_i
);

    localparam int ID_W  = (`UDMA_N_CH > 1) ? $clog2(`UDMA_N_CH) : 1;
    localparam int PTR_W = $clog2(`UDMA_ID_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`UDMA_ID_FIFO_DEPTH + 1);

    typedef logic [ID_W-1:0] ch_id_t;

    ch_id_t              last_q;
    ch_id_t              win_id;
    logic                win_valid;
    logic                fifo_full;
    logic                push;
    logic                pop;
    ch_id_t              id_mem [`UDMA_ID_FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr_q;
    logic [PTR_W-1:0]    rd_ptr_q;
    logic [CNT_W-1:0]    count_q;

    // search starts just after the last winner
    always_comb begin
        int idx;
        win_valid = 1'b0;
        win_id    = '0;
        for (int i = 1; i <= `UDMA_N_CH; i++) begin
            idx = (int'(last_q) + i) % `UDMA_N_CH;
            if (!win_valid && ch_req_i[idx]) begin
                win_valid = 1'b1;
                win_id    = ch_id_t'(idx);
            end
        end
    end

    assign fifo_full = count_q == CNT_W'(`UDMA_ID_FIFO_DEPTH);
    assign l2_req_o  = win_valid && !fifo_full;
    assign l2_addr_o = ch_addr_i[win_id];
    assign push      = l2_req_o && l2_gnt_i;
    assign pop       = l2_rvalid_i;

    always_comb begin
        for (int i = 0; i < `UDMA_N_CH; i++) begin
            ch_gnt_o[i]    = push && (int'(win_id) == i);
            ch_rvalid_o[i] = pop && (int'(id_mem[rd_ptr_q]) == i);
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            last_q   <= ch_id_t'(`UDMA_N_CH - 1);
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                last_q   <= win_id;
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // owner of each read in flight
    always_ff @(posedge sys_clk_i) begin
        if (push) begin
            id_mem[wr_ptr_q] <= win_id;
        end
    end

    a_rvalid_owned: assert property (
        @(posedge sys_clk_i) disable iff (!rst_n_i)
        l2_rvalid_i |-> count_q != '0
    );

    // a push never lands on a slot that still holds an owner
    a_no_push_full: assert property (
        @(posedge sys_clk_i) disable iff (!rst_n_i)
        push |-> (wr_ptr_q != rd_ptr_q) || (count_q == '0)
    );

endmodule

`default_nettype wire

//--- src/udma_lin_tx_ch.sv
// linear tx channel; one L2 read outstanding, word-aligned start and size, no stream back-pressure
`include "udma_defines.svh"

`default_nettype none

module udma_lin_tx_ch (
    input  wire logic                 sys_clk_i,
    input  wire logic                 rst_n_i,
    input  wire udma_pkg::reg_addr_t  cfg_addr_i,
    input  wire udma_pkg::l2_data_t   cfg_wdata_i,
    input  wire logic                 cfg_we_i,
    output udma_pkg::l2_data_t        cfg_rdata_o,
    output logic                      l2_req_o,
    output udma_pkg::l2_addr_t        l2_addr_o,
    input  wire logic                 l2_gnt_i,
    input  wire logic                 l2_rvalid_i,
    input  wire udma_pkg::l2_data_t   l2_rdata_i,
    output logic                      tx_valid_o,
    output udma_pkg::l2_data_t        tx_data_o,
    output logic                      eot_o
);

    import udma_pkg::*;

    ch_state_e    state_q;
    l2_addr_t     saddr_q;
    trans_size_t  size_q;
    l2_addr_t     cur_addr_q;
    trans_size_t  left_q;
    logic         tx_valid_q;
    l2_data_t     tx_data_q;
    logic         eot_q;
    logic         busy;
    logic         start;
    logic         resp;

    assign busy  = state_q != CH_IDLE;
    assign start = cfg_we_i && !busy && (cfg_addr_i == `UDMA_REG_CFG) &&
                   cfg_wdata_i[0] && (size_q != '0);
    assign resp  = (state_q == CH_WAIT) && l2_rvalid_i;

    // config registers, frozen while a transfer runs
    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            saddr_q <= '0;
            size_q  <= '0;
        end else if (cfg_we_i && !busy) begin
            if (cfg_addr_i == `UDMA_REG_SADDR) begin
                saddr_q <= cfg_wdata_i;
            end
            if (cfg_addr_i == `UDMA_REG_SIZE) begin
                size_q <= cfg_wdata_i[`UDMA_TRANS_SIZE-1:0];
            end
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            state_q    <= CH_IDLE;
            cur_addr_q <= '0;
            left_q     <= '0;
            tx_valid_q <= 1'b0;
            eot_q      <= 1'b0;
        end else begin
            tx_valid_q <= resp;
            eot_q      <= 1'b0;
            case (state_q)
                CH_IDLE: begin
                    if (start) begin
                        cur_addr_q <= saddr_q;
                        left_q     <= size_q;
                        state_q    <= CH_REQ;
                    end
                end
                CH_REQ: begin
                    if (l2_gnt_i) begin
                        state_q <= CH_WAIT;
                    end
                end
                CH_WAIT: begin
                    if (l2_rvalid_i) begin
                        // last word when 4 bytes or fewer remain
                        if (left_q <= trans_size_t'(4)) begin
                            left_q  <= '0;
                            eot_q   <= 1'b1;
                            state_q <= CH_IDLE;
                        end else begin
                            left_q     <= left_q - trans_size_t'(4);
                            cur_addr_q <= cur_addr_q + l2_addr_t'(4);
                            state_q    <= CH_REQ;
                        end
                    end
                end
                default: state_q <= CH_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (resp) begin
            tx_data_q <= l2_rdata_i;
        end
    end

    assign l2_req_o   = state_q == CH_REQ;
    assign l2_addr_o  = cur_addr_q;
    assign tx_valid_o = tx_valid_q;
    assign tx_data_o  = tx_data_q;
    assign eot_o      = eot_q;

    // register read for the shared offset
    always_comb begin
        case (cfg_addr_i)
            `UDMA_REG_SADDR: cfg_rdata_o = saddr_q;
            `UDMA_REG_SIZE:  cfg_rdata_o = l2_data_t'(size_q);
            `UDMA_REG_CFG:   cfg_rdata_o = l2_data_t'({busy, 1'b0});
            `UDMA_REG_LEFT:  cfg_rdata_o = l2_data_t'(left_q);
            default:         cfg_rdata_o = '0;
        endcase
    end

    a_req_stable: assert property (
        @(posedge sys_clk_i) disable iff (!rst_n_i)
        l2_req_o && !l2_gnt_i |=> l2_req_o && $stable(l2_addr_o)
    );

endmodule

`default_nettype wire

//--- src/udma_pkg.sv
// shared uDMA types; widths follow udma_defines.svh, addresses are byte addresses
`include "udma_defines.svh"

`default_nettype none

package udma_pkg;

    // byte address into L2
    typedef logic [`UDMA_L2_WIDTH-1:0] l2_addr_t;

    // one L2 word
    typedef logic [`UDMA_L2_WIDTH-1:0] l2_data_t;

    // register offset inside a slot
    typedef logic [`UDMA_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // peripheral slot index
    typedef logic [`UDMA_SLOT_WIDTH-1:0] slot_id_t;

    // byte count of a transfer
    typedef logic [`UDMA_TRANS_SIZE-1:0] trans_size_t;

    // event group of one slot, bit 0 is end of transfer
    typedef logic [`UDMA_EVT_WIDTH-1:0] udma_evt_t;

    // linear tx channel
    typedef enum logic [1:0] {
        CH_IDLE,
        CH_REQ,
        CH_WAIT
    } ch_state_e;

endpackage

`default_nettype wire

//--- src/udma_subsystem.sv
// uDMA top with tx channels only; single clock, event slots from UDMA_N_CH up read as zero
`include "udma_defines.svh"

`default_nettype none

module udma_subsystem (
    input  wire logic                                       sys_clk_i,
    input  wire logic                                       rst_n_i,
    input  wire logic [`UDMA_APB_ADDR_WIDTH-1:0]            apb_paddr_i,
    input  wire udma_pkg::l2_data_t                         apb_pwdata_i,
    input  wire logic                                       apb_pwrite_i,
    input  wire logic                                       apb_psel_i,
    input  wire logic                                       apb_penable_i,
    output udma_pkg::l2_data_t                              apb_prdata_o,
    output logic                                            apb_pready_o,
    output logic                                            apb_pslverr_o,
    output logic                                            l2_req_o,
    output udma_pkg::l2_addr_t                              l2_addr_o,
    input  wire logic                                       l2_gnt_i,
    input  wire logic                                       l2_rvalid_i,
    input  wire udma_pkg::l2_data_t                         l2_rdata_i,
    output logic [`UDMA_N_CH-1:0]                           tx_valid_o,
    output udma_pkg::l2_data_t [`UDMA_N_CH-1:0]             tx_data_o,
    output udma_pkg::udma_evt_t [`UDMA_EVT_SLOTS-1:0]       events_o
);

    import udma_pkg::*;

    reg_addr_t                    cfg_addr;
    l2_data_t                     cfg_wdata;
    logic [`UDMA_N_CH-1:0]        cfg_we;
    l2_data_t [`UDMA_N_CH-1:0]    ch_rdata;
    logic [`UDMA_N_CH-1:0]        ch_req;
    l2_addr_t [`UDMA_N_CH-1:0]    ch_addr;
    logic [`UDMA_N_CH-1:0]        ch_gnt;
    logic [`UDMA_N_CH-1:0]        ch_rvalid;
    logic [`UDMA_N_CH-1:0]        ch_eot;

    udma_apb_cfg i_apb_cfg (
        .sys_clk_i     (sys_clk_i),
        .rst_n_i       (rst_n_i),
        .apb_paddr_i   (apb_paddr_i),
        .apb_pwdata_i  (apb_pwdata_i),
        .apb_pwrite_i  (apb_pwrite_i),
        .apb_psel_i    (apb_psel_i),
        .apb_penable_i (apb_penable_i),
        .ch_rdata_i    (ch_rdata),
        .apb_prdata_o  (apb_prdata_o),
        .apb_pready_o  (apb_pready_o),
        .apb_pslverr_o (apb_pslverr_o),
        .cfg_addr_o    (cfg_addr),
        .cfg_wdata_o   (cfg_wdata),
        .cfg_we_o      (cfg_we)
    );

    for (genvar g = 0; g < `UDMA_N_CH; g++) begin : g_ch
        udma_lin_tx_ch i_tx_ch (
            .sys_clk_i   (sys_clk_i),
            .rst_n_i     (rst_n_i),
            .cfg_addr_i  (cfg_addr),
            .cfg_wdata_i (cfg_wdata),
            .cfg_we_i    (cfg_we[g]),
            .cfg_rdata_o (ch_rdata[g]),
            .l2_req_o    (ch_req[g]),
            .l2_addr_o   (ch_addr[g]),
            .l2_gnt_i    (ch_gnt[g]),
            .l2_rvalid_i (ch_rvalid[g]),
            .l2_rdata_i  (l2_rdata_i),
            .tx_valid_o  (tx_valid_o[g]),
            .tx_data_o   (tx_data_o[g]),
            .eot_o       (ch_eot[g])
        );
        // eot on bit 0 of the channel slot
        assign events_o[g] = udma_evt_t'(ch_eot[g]);
    end

    // unused slots
    for (genvar g = `UDMA_N_CH; g < `UDMA_EVT_SLOTS; g++) begin : g_evt_zero
        assign events_o[g] = '0;
    end

    udma_l2_rd_arb i_l2_rd_arb (
        .sys_clk_i   (sys_clk_i),
        .rst_n_i     (rst_n_i),
        .ch_req_i    (ch_req),
        .ch_addr_i   (ch_addr),
        .ch_gnt_o    (ch_gnt),
        .ch_rvalid_o (ch_rvalid),
        .l2_req_o    (l2_req_o),
        .l2_addr_o   (l2_addr_o),
        .l2_gnt_i    (l2_gnt_i),
        .l2_rvalid_i (l2_rvalid_i)
    );

endmodule

`default_nettype wire
